/* flist.f */
common/cpu_pkg.sv
common/ex_mem_if.sv
hw/reg_file.sv
hw/alu.sv
hw/control_unit.sv
hw/ex_mem.sv
hw/hazard_unit.sv
hw/cpu_top.sv
+incdir+test
test/tb_cpu.sv

/* Makefile */
# Verilator build for the pipelined CPU testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu

# The simulator exits with a failing status when the testbench stops on $fatal
run: compile
	./obj_dir/tb_cpu

clean:
	rm -rf obj_dir

/* test/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [15:0] model_regs [4];
logic [15:0] model_mem [data_words];
logic [15:0] model_out [$];    // WWD values in program order

// Executes the program in imem one instruction at a time, starting from dmem_init
task automatic run_isa_model();
    logic [15:0] pc;
    logic [15:0] pc1;
    logic [15:0] ins;
    logic [15:0] imm;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] addr;
    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [1:0]  rd;
    bit          halted;
    int          steps;
    pc = reset_pc;
    halted = 1'b0;
    steps = 0;
    for (int i = 0; i < 4; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < data_words; i++) begin
        model_mem[i] = dmem_init[i];
    end
    model_out.delete();
    while (!halted && steps < 4 * imem_words) begin
        ins  = fetch_word(pc);
        pc1  = pc + 16'd1;
        rs   = ins[11:10];
        rt   = ins[9:8];
        rd   = ins[7:6];
        imm  = {{8{ins[7]}}, ins[7:0]};
        a    = model_regs[rs];
        b    = model_regs[rt];
        addr = a + imm;
        pc   = pc1;
        case (ins[15:12])
            op_alu_r: begin
                case (ins[5:0])
                    func_add: model_regs[rd] = a + b;
                    func_sub: model_regs[rd] = a - b;
                    func_and: model_regs[rd] = a & b;
                    func_orr: model_regs[rd] = a | b;
                    default: ;
                endcase
            end
            op_adi: model_regs[rt] = a + imm;
            op_lwd: model_regs[rt] = model_mem[addr[3:0]];    // Region repeats every 16 words
            op_swd: model_mem[addr[3:0]] = b;
            op_beq: if (a == b) pc = pc1 + imm;
            op_bne: if (a != b) pc = pc1 + imm;
            op_jmp: pc = {pc1[15:12], ins[11:0]};
            op_sys: begin
                if (ins[5:0] == func_wwd) begin
                    model_out.push_back(a);
                end else if (ins[5:0] == func_hlt) begin
                    halted = 1'b1;
                end
            end
            default: ;
        endcase
        steps++;
    end
endtask

`endif

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int prog_len         = 48;
    localparam int imem_words       = 64;
    localparam int data_words       = 16;
    localparam int timeout_cycles   = 10 * prog_len + 100;
    localparam int halt_hold_cycles = 10;

    logic        clk;
    logic        reset_n;
    logic [15:0] i_address;
    logic [15:0] i_data = '0;
    logic [15:0] d_address;
    logic        d_read;
    logic        d_write;
    logic [15:0] d_wdata;
    logic [15:0] d_rdata = '0;
    logic [15:0] output_port;
    logic        output_valid;
    logic        done;

    int          seed;
    logic [15:0] imem [imem_words];
    logic [15:0] dmem [data_words];
    logic [15:0] dmem_init [data_words];
    int          out_count = 0;
    int          cycle_count = 0;
    bit          running = 1'b0;

    `include "isa_model.svh"

    cpu_top u_cpu_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_address    (i_address),
        .i_data       (i_data),
        .d_address    (d_address),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        if (addr < 16'(imem_words)) begin
            return imem[addr[5:0]];
        end
        return '0;    // Past the program the memory reads as no-ops
    endfunction

    function logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic logic [5:0] pick_alu_func(input logic [1:0] sel);
        case (sel)
            2'd0:    return func_add;
            2'd1:    return func_sub;
            2'd2:    return func_and;
            default: return func_orr;
        endcase
    endfunction

    task stop_with_failure(input string reason);
        $display("Finished with errors");
        $fatal(1, "%s", reason);
    endtask

    task check_value(input string name, input logic [15:0] got, input logic [15:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            stop_with_failure("A checked value did not match the model");
        end
    endtask

    task build_program();
        logic [31:0] r;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [1:0]  rd;
        logic [7:0]  imm;
        int          kind;
        int          off;
        int          jmp_pos;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0;
        end
        r = next_rand();
        jmp_pos = int'(r % 44);
        for (int i = 0; i < prog_len; i++) begin
            r    = next_rand();
            rs   = r[1:0];
            rt   = r[3:2];
            rd   = r[5:4];
            imm  = r[15:8];
            off  = int'(r[7:6]) + 1;    // Forward by 1 to 4 and never past the HLT
            kind = int'(r[31:16] % 7);
            if (i == jmp_pos) begin
                imem[i] = {op_jmp, 12'(i + 1 + off)};
            end else begin
                case (kind)
                    0: imem[i] = {op_alu_r, rs, rt, rd, pick_alu_func(r[7:6])};
                    1: imem[i] = {op_adi, rs, rt, imm};
                    2: imem[i] = {op_lwd, rs, rt, imm};
                    3: imem[i] = {op_swd, rs, rt, imm};
                    4: imem[i] = {op_beq, rs, rt, 8'(off)};
                    5: imem[i] = {op_bne, rs, rt, 8'(off)};
                    default: imem[i] = {op_sys, rs, 4'b0000, func_wwd};
                endcase
            end
        end
        for (int k = 0; k < 4; k++) begin
            imem[prog_len + k] = {op_sys, 2'(k), 4'b0000, func_wwd};
        end
        imem[prog_len + 4] = {op_sys, 6'b000000, func_hlt};
        for (int k = 0; k < data_words; k++) begin
            r = next_rand();
            dmem_init[k] = r[15:0];
        end
    endtask

    // The memory side of the DUT commits stores here and drives its responses for the next edge
    always @(negedge clk) begin
        if (!running) begin
            for (int k = 0; k < data_words; k++) begin
                dmem[k] = dmem_init[k];
            end
        end else begin
            cycle_count++;
            if (cycle_count > timeout_cycles) begin
                stop_with_failure("Timeout: the processor did not halt in time");
            end
            if (d_write) begin
                dmem[d_address[3:0]] = d_wdata;
            end
            if (output_valid) begin
                if (out_count >= model_out.size()) begin
                    stop_with_failure("An output pulse appeared that the model does not expect");
                end else begin
                    check_value("output_port", output_port, model_out[out_count]);
                    out_count++;
                end
            end
        end
        i_data  = fetch_word(i_address);
        d_rdata = d_read ? dmem[d_address[3:0]] : '0;    // Read data only while a load asks
    end

    initial begin
        seed = 21838;
        reset_n = 1'b1;
        build_program();
        run_isa_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("d_read", 16'(d_read), 16'h0);
        check_value("d_write", 16'(d_write), 16'h0);
        check_value("output_valid", 16'(output_valid), 16'h0);
        check_value("done", 16'(done), 16'h0);
        check_value("i_address", i_address, reset_pc);
        reset_n = 1'b0;
        @(posedge clk);
        running = 1'b1;
        while (!done) begin
            @(negedge clk);
        end
        repeat (halt_hold_cycles) begin
            @(negedge clk);
            check_value("done", 16'(done), 16'h1);
            check_value("d_write", 16'(d_write), 16'h0);
        end
        @(posedge clk);
        check_value("output pulse count", 16'(out_count), 16'(model_out.size()));
        for (int k = 0; k < data_words; k++) begin
            check_value($sformatf("dmem[%0d]", k), dmem[k], model_mem[k]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                          clk,
    input  logic                          reset_n,
    output logic [cpu_pkg::word_size-1:0] i_address,
    input  logic [cpu_pkg::word_size-1:0] i_data,
    output logic [cpu_pkg::word_size-1:0] d_address,
    output logic                          d_read,
    output logic                          d_write,
    output logic [cpu_pkg::word_size-1:0] d_wdata,
    input  logic [cpu_pkg::word_size-1:0] d_rdata,
    output logic [cpu_pkg::word_size-1:0] output_port,
    output logic                          output_valid,
    output logic                          done
);
    import cpu_pkg::*;

    logic [word_size-1:0]      pc;
    logic [word_size-1:0]      pc_plus1;
    logic                      fetch_halt;
    logic                      fetch_stop;
    logic [word_size-1:0]      if_id_instr;
    logic [word_size-1:0]      if_id_pc1;
    logic [reg_addr_width-1:0] id_rs;
    logic [reg_addr_width-1:0] id_rt;
    logic [reg_addr_width-1:0] id_dest;
    logic [word_size-1:0]      id_rs_data;
    logic [word_size-1:0]      id_rt_data;
    logic [word_size-1:0]      id_imm;
    alu_op_t                   id_alu_op;
    logic                      id_alu_src_imm;
    logic                      id_reg_dst_rd;
    logic                      id_reg_write;
    logic                      id_mem_read;
    logic                      id_mem_write;
    logic                      id_mem_to_reg;
    logic                      id_b_op;
    logic                      id_branch_ne;
    logic                      id_jump;
    logic                      id_is_wwd;
    logic                      id_is_done;
    logic                      id_uses_rs;
    logic                      id_uses_rt;
    logic [word_size-1:0]      id_ex_pc1;
    logic [word_size-1:0]      id_ex_r1;
    logic [word_size-1:0]      id_ex_r2;
    logic [word_size-1:0]      id_ex_imm;
    logic [jtarget_hi:jtarget_lo] id_ex_jaddr;
    logic [reg_addr_width-1:0] id_ex_rd;
    alu_op_t                   id_ex_alu_op;
    logic                      id_ex_alu_src_imm;
    logic                      id_ex_reg_write;
    logic                      id_ex_mem_read;
    logic                      id_ex_mem_write;
    logic                      id_ex_mem_to_reg;
    logic                      id_ex_b_op;
    logic                      id_ex_branch_ne;
    logic                      id_ex_jump;
    logic                      id_ex_is_wwd;
    logic                      id_ex_is_done;
    logic [word_size-1:0]      ex_alu_b;
    logic                      ex_equal;
    logic [reg_addr_width-1:0] mem_wb_rd;
    logic                      mem_wb_reg_write;
    logic                      mem_wb_mem_to_reg;
    logic [word_size-1:0]      mem_wb_alu;
    logic [word_size-1:0]      mem_wb_rdata;
    logic [word_size-1:0]      wb_data;
    logic                      stall;
    logic                      flush;
    pc_src_t                   next_pc_src;

    ex_mem_if ex_src ();
    ex_mem_if ex_snk ();

    // Fetch stops once a halt has been decoded
    assign fetch_stop = fetch_halt || id_is_done;
    assign pc_plus1   = pc + word_size'(1);
    assign i_address  = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= reset_pc;
        end else if (next_pc_src != pc_seq) begin
            pc <= ex_snk.target_address;
        end else if (!stall && !fetch_stop) begin
            pc <= pc_plus1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            fetch_halt <= 1'b0;    // A flushed halt lets fetch resume at the target
        end else if (id_is_done) begin
            fetch_halt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            if_id_instr <= '0;
        end else if (!stall) begin
            if_id_instr <= fetch_stop ? '0 : i_data;
            if_id_pc1   <= pc_plus1;
        end
    end

    assign id_rs   = if_id_instr[rs_hi:rs_lo];
    assign id_rt   = if_id_instr[rt_hi:rt_lo];
    assign id_dest = id_reg_dst_rd ? if_id_instr[rd_hi:rd_lo] : id_rt;
    assign id_imm  = {{(word_size - (imm_hi - imm_lo + 1)){if_id_instr[imm_hi]}},
                      if_id_instr[imm_hi:imm_lo]};

    reg_file u_reg_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_addr (id_rs),
        .rt_addr (id_rt),
        .rs_data (id_rs_data),
        .rt_data (id_rt_data),
        .wr_en   (mem_wb_reg_write),
        .wr_addr (mem_wb_rd),
        .wr_data (wb_data)
    );

    control_unit u_control_unit (
        .instr       (if_id_instr),
        .alu_op      (id_alu_op),
        .alu_src_imm (id_alu_src_imm),
        .reg_dst_rd  (id_reg_dst_rd),
        .reg_write   (id_reg_write),
        .mem_read    (id_mem_read),
        .mem_write   (id_mem_write),
        .mem_to_reg  (id_mem_to_reg),
        .b_op        (id_b_op),
        .branch_ne   (id_branch_ne),
        .jump        (id_jump),
        .is_wwd      (id_is_wwd),
        .is_done     (id_is_done),
        .uses_rs     (id_uses_rs),
        .uses_rt     (id_uses_rt)
    );

    hazard_unit u_hazard_unit (
        .rs               (id_rs),
        .rt               (id_rt),
        .uses_rs          (id_uses_rs),
        .uses_rt          (id_uses_rt),
        .id_ex_rd         (id_ex_rd),
        .id_ex_reg_write  (id_ex_reg_write),
        .ex_mem           (ex_snk.sink),
        .mem_wb_rd        (mem_wb_rd),
        .mem_wb_reg_write (mem_wb_reg_write),
        .stall            (stall),
        .flush            (flush),
        .next_pc_src      (next_pc_src)
    );

    // A stall or a flush turns the decoded instruction into a bubble
    always_ff @(posedge clk) begin
        if (reset_n || flush || stall) begin
            id_ex_reg_write <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_b_op      <= 1'b0;
            id_ex_jump      <= 1'b0;
            id_ex_is_wwd    <= 1'b0;
            id_ex_is_done   <= 1'b0;
        end else begin
            id_ex_reg_write <= id_reg_write;
            id_ex_mem_read  <= id_mem_read;
            id_ex_mem_write <= id_mem_write;
            id_ex_b_op      <= id_b_op;
            id_ex_jump      <= id_jump;
            id_ex_is_wwd    <= id_is_wwd;
            id_ex_is_done   <= id_is_done;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc1         <= if_id_pc1;
        id_ex_r1          <= id_rs_data;
        id_ex_r2          <= id_rt_data;
        id_ex_imm         <= id_imm;
        id_ex_jaddr       <= if_id_instr[jtarget_hi:jtarget_lo];
        id_ex_rd          <= id_dest;
        id_ex_alu_op      <= id_alu_op;
        id_ex_alu_src_imm <= id_alu_src_imm;
        id_ex_mem_to_reg  <= id_mem_to_reg;
        id_ex_branch_ne   <= id_branch_ne;
    end

    assign ex_alu_b = id_ex_alu_src_imm ? id_ex_imm : id_ex_r2;

    alu u_alu (
        .a      (id_ex_r1),
        .b      (ex_alu_b),
        .op     (id_ex_alu_op),
        .result (ex_src.alu_result),
        .equal  (ex_equal)
    );

    assign ex_src.target_address = id_ex_jump
                                 ? {id_ex_pc1[word_size-1:jtarget_hi+1], id_ex_jaddr}
                                 : id_ex_pc1 + id_ex_imm;
    assign ex_src.b_cond     = id_ex_branch_ne ? !ex_equal : ex_equal;
    assign ex_src.r_data1    = id_ex_r1;
    assign ex_src.r_data2    = id_ex_r2;
    assign ex_src.rd         = id_ex_rd;
    assign ex_src.pc_src     = id_ex_jump ? pc_jump : (id_ex_b_op ? pc_branch : pc_seq);
    assign ex_src.mem_read   = id_ex_mem_read;
    assign ex_src.mem_write  = id_ex_mem_write;
    assign ex_src.b_op       = id_ex_b_op;
    assign ex_src.reg_write  = id_ex_reg_write;
    assign ex_src.mem_to_reg = id_ex_mem_to_reg;
    assign ex_src.is_wwd     = id_ex_is_wwd;
    assign ex_src.is_done    = id_ex_is_done && !flush;  // Halt behind a taken branch is dropped

    ex_mem u_ex_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (flush),
        .d       (ex_src.sink),
        .q       (ex_snk.source)
    );

    assign d_address = ex_snk.alu_result;
    assign d_read    = ex_snk.mem_read;
    assign d_write   = ex_snk.mem_write;
    assign d_wdata   = ex_snk.r_data2;

    // The output port and done flag are updated with the writeback stage
    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb_reg_write <= 1'b0;
            output_valid     <= 1'b0;
            done             <= 1'b0;
        end else begin
            mem_wb_reg_write <= ex_snk.reg_write;
            output_valid     <= ex_snk.is_wwd;
            done             <= done || ex_snk.is_done;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd         <= ex_snk.rd;
        mem_wb_mem_to_reg <= ex_snk.mem_to_reg;
        mem_wb_alu        <= ex_snk.alu_result;
        mem_wb_rdata      <= d_rdata;
        output_port       <= ex_snk.r_data1;
    end

    assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_alu;

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_width-1:0] rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt,
    input  logic                               uses_rs,
    input  logic                               uses_rt,
    input  logic [cpu_pkg::reg_addr_width-1:0] id_ex_rd,
    input  logic                               id_ex_reg_write,
    ex_mem_if.sink                             ex_mem,
    input  logic [cpu_pkg::reg_addr_width-1:0] mem_wb_rd,
    input  logic                               mem_wb_reg_write,
    output logic                               stall,
    output logic                               flush,
    output cpu_pkg::pc_src_t                   next_pc_src
);
    import cpu_pkg::*;

    logic rs_busy;
    logic rt_busy;

    assign rs_busy = (id_ex_reg_write && id_ex_rd == rs)
                   || (ex_mem.reg_write && ex_mem.rd == rs)
                   || (mem_wb_reg_write && mem_wb_rd == rs);
    assign rt_busy = (id_ex_reg_write && id_ex_rd == rt)
                   || (ex_mem.reg_write && ex_mem.rd == rt)
                   || (mem_wb_reg_write && mem_wb_rd == rt);

    always_comb begin
        next_pc_src = pc_seq;
        if (ex_mem.pc_src == pc_jump) begin
            next_pc_src = pc_jump;
        end else if (ex_mem.b_op && ex_mem.b_cond) begin
            next_pc_src = pc_branch;
        end
    end

    assign flush = (next_pc_src != pc_seq);
    assign stall = !flush && ((uses_rs && rs_busy) || (uses_rt && rt_busy));  // Flush wins

    always_comb begin
        assert (!ex_mem.b_op || ex_mem.pc_src == pc_branch);    // Execute tags every branch
    end

endmodule

/* hw/ex_mem.sv */
`timescale 1ns/1ps

module ex_mem (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       flush,
    ex_mem_if.sink     d,
    ex_mem_if.source   q
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            q.target_address <= '0;
            q.b_cond         <= 1'b0;
            q.alu_result     <= '0;
            q.r_data1        <= '0;
            q.r_data2        <= '0;
            q.rd             <= '0;
            q.pc_src         <= pc_seq;
            q.mem_read       <= 1'b0;
            q.mem_write      <= 1'b0;
            q.b_op           <= 1'b0;
            q.reg_write      <= 1'b0;
            q.mem_to_reg     <= 1'b0;
            q.is_wwd         <= 1'b0;
        end else begin
            q.target_address <= d.target_address;
            q.b_cond         <= d.b_cond;
            q.alu_result     <= d.alu_result;
            q.r_data1        <= d.r_data1;
            q.r_data2        <= d.r_data2;
            q.rd             <= d.rd;
            q.pc_src         <= d.pc_src;
            q.mem_read       <= d.mem_read;
            q.mem_write      <= d.mem_write;
            q.b_op           <= d.b_op;
            q.reg_write      <= d.reg_write;
            q.mem_to_reg     <= d.mem_to_reg;
            q.is_wwd         <= d.is_wwd;
        end
    end

    // A halt sitting here is never younger than the branch that flushes
    always_ff @(posedge clk) begin
        if (reset_n) begin
            q.is_done <= 1'b0;
        end else begin
            q.is_done <= d.is_done;
        end
    end

    // Decode never gives one instruction both a load and a store
    assert property (@(posedge clk) disable iff (reset_n) !(q.mem_read && q.mem_write));

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic [cpu_pkg::word_size-1:0] instr,
    output cpu_pkg::alu_op_t              alu_op,
    output logic                          alu_src_imm,
    output logic                          reg_dst_rd,
    output logic                          reg_write,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          mem_to_reg,
    output logic                          b_op,
    output logic                          branch_ne,
    output logic                          jump,
    output logic                          is_wwd,
    output logic                          is_done,
    output logic                          uses_rs,
    output logic                          uses_rt
);
    import cpu_pkg::*;

    opcode_t    opcode;
    logic [5:0] func;

    assign opcode = opcode_t'(instr[opcode_hi:opcode_lo]);
    assign func   = instr[func_hi:func_lo];

    always_comb begin
        alu_op      = alu_pass_b;
        alu_src_imm = 1'b0;
        reg_dst_rd  = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        b_op        = 1'b0;
        branch_ne   = 1'b0;
        jump        = 1'b0;
        is_wwd      = 1'b0;
        is_done     = 1'b0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        case (opcode)
            op_alu_r: begin
                reg_dst_rd = 1'b1;
                reg_write  = 1'b1;
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
                case (func)
                    func_add: alu_op = alu_add;
                    func_sub: alu_op = alu_sub;
                    func_and: alu_op = alu_and;
                    func_orr: alu_op = alu_or;
                    default: begin
                        reg_write = 1'b0;
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                endcase
            end
            op_adi, op_lwd: begin
                alu_op      = alu_add;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;    // Destination is rt
                uses_rs     = 1'b1;
                mem_read    = (opcode == op_lwd);
                mem_to_reg  = (opcode == op_lwd);
            end
            op_swd: begin
                alu_op      = alu_add;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            op_beq, op_bne: begin
                alu_op    = alu_sub;
                b_op      = 1'b1;
                branch_ne = (opcode == op_bne);
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            op_jmp: jump = 1'b1;
            op_sys: begin
                if (func == func_wwd) begin
                    is_wwd  = 1'b1;
                    uses_rs = 1'b1;
                end else if (func == func_hlt) begin
                    is_done = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::word_size-1:0] a,
    input  logic [cpu_pkg::word_size-1:0] b,
    input  cpu_pkg::alu_op_t              op,
    output logic [cpu_pkg::word_size-1:0] result,
    output logic                          equal
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    assign equal = (a == b);    // Branch condition before BNE inversion

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
    output logic [cpu_pkg::word_size-1:0]      rs_data,
    output logic [cpu_pkg::word_size-1:0]      rt_data,
    input  logic                               wr_en,
    input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [cpu_pkg::word_size-1:0]      wr_data
);
    import cpu_pkg::*;

    logic [word_size-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // A write in this cycle is seen by a read of the same register
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

/* common/ex_mem_if.sv */
`timescale 1ns/1ps

interface ex_mem_if;
    import cpu_pkg::*;

    logic [word_size-1:0]      target_address;
    logic                      b_cond;
    logic [word_size-1:0]      alu_result;     // Also the data address
    logic [word_size-1:0]      r_data1;        // Value for WWD
    logic [word_size-1:0]      r_data2;        // Store data
    logic [reg_addr_width-1:0] rd;
    pc_src_t                   pc_src;
    logic                      mem_read;
    logic                      mem_write;
    logic                      b_op;
    logic                      reg_write;
    logic                      mem_to_reg;
    logic                      is_wwd;
    logic                      is_done;

    modport source (
        output target_address, b_cond, alu_result, r_data1, r_data2, rd,
        output pc_src,
        output mem_read, mem_write, b_op, reg_write, mem_to_reg,
        output is_wwd, is_done
    );

    modport sink (
        input target_address, b_cond, alu_result, r_data1, r_data2, rd,
        input pc_src,
        input mem_read, mem_write, b_op, reg_write, mem_to_reg,
        input is_wwd, is_done
    );

endinterface

/* common/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_size      = 16;
    localparam int reg_addr_width = 2;

    localparam int opcode_hi  = 15;
    localparam int opcode_lo  = 12;
    localparam int rs_hi      = 11;
    localparam int rs_lo      = 10;
    localparam int rt_hi      = 9;
    localparam int rt_lo      = 8;
    localparam int rd_hi      = 7;
    localparam int rd_lo      = 6;
    localparam int func_hi    = 5;
    localparam int func_lo    = 0;
    localparam int imm_hi     = 7;
    localparam int imm_lo     = 0;
    localparam int jtarget_hi = 11;
    localparam int jtarget_lo = 0;

    localparam logic [5:0] func_add = 6'd0;
    localparam logic [5:0] func_sub = 6'd1;
    localparam logic [5:0] func_and = 6'd2;
    localparam logic [5:0] func_orr = 6'd3;
    localparam logic [5:0] func_wwd = 6'd28;
    localparam logic [5:0] func_hlt = 6'd29;

    localparam logic [word_size-1:0] reset_pc = '0;

    // An all-zero word is a SYS instruction with no function, which is a no-op
    typedef enum logic [3:0] {
        op_sys   = 4'd0,
        op_beq   = 4'd1,
        op_bne   = 4'd2,
        op_adi   = 4'd4,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_alu_r = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        pc_seq,
        pc_branch,
        pc_jump
    } pc_src_t;

endpackage
